/* fpu_cmp_config.svh */
// widths of the fp32 word fields and the canonical quiet nan
`ifndef FPU_CMP_CONFIG_SVH
`define FPU_CMP_CONFIG_SVH

// single precision layout
`define FPU_EXP_W 8
`define FPU_MAN_W 23

// full operand word
`define FPU_WORD_W 32

// canonical quiet nan with positive sign and only the top mantissa bit set
`define FPU_QNAN {1'b0, {`FPU_EXP_W{1'b1}}, 1'b1, {(`FPU_MAN_W-1){1'b0}}}

`endif

/* fpu_cmp_pkg.sv */
// package with the compare operation enum and the fp32 operand union
`default_nettype none

`include "fpu_cmp_config.svh"

package fpu_cmp_pkg;

  // codes 5 to 7 are reserved
  typedef enum logic [2:0] {
    OP_EQ  = 3'd0,
    OP_LT  = 3'd1,
    OP_LE  = 3'd2,
    OP_MIN = 3'd3,
    OP_MAX = 3'd4
  } cmp_op_e;

  // ieee field layout
  typedef struct packed {
    logic                  sign;
    logic [`FPU_EXP_W-1:0] exponent;
    logic [`FPU_MAN_W-1:0] mantissa;
  } fp32_fields_t;

  // sign and magnitude, exponent and mantissa taken as one unsigned number
  typedef struct packed {
    logic                   sign;
    logic [`FPU_WORD_W-2:0] mag;
  } fp32_mag_t;

  typedef union packed {
    fp32_fields_t f;
    fp32_mag_t    m;
  } fp32_u;

endpackage

`default_nettype wire

/* fpu_cmp_res_if.sv */
// interface for the raw compare and min-max results of the core
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

interface fpu_cmp_res_if;

  logic                   eq;
  logic                   lt;
  logic                   le;
  logic                   lt_le_invalid;
  logic                   eq_invalid;
  logic [`FPU_WORD_W-1:0] min;
  logic [`FPU_WORD_W-1:0] max;
  logic                   min_max_invalid;

  // combinational from the registered operands, no handshake
  modport core (
    output eq, lt, le, lt_le_invalid, eq_invalid,
    output min, max, min_max_invalid
  );

  modport exec (
    input eq, lt, le, lt_le_invalid, eq_invalid,
    input min, max, min_max_invalid
  );

endinterface

`default_nettype wire

/* fpu_classify.sv */
// fp32 operand classifier for zero, nan, signaling nan, infinity and sign
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

module fpu_classify
  import fpu_cmp_pkg::*;
(
  input  fp32_u operand_i,
  output logic  zero_o,
  output logic  nan_o,
  output logic  sig_nan_o,
  output logic  infty_o,
  output logic  sign_o
);

  logic exp_ones;
  logic exp_zero;
  logic man_zero;

  // field view of the word
  assign exp_ones = &operand_i.f.exponent;
  assign exp_zero = ~|operand_i.f.exponent;
  assign man_zero = ~|operand_i.f.mantissa;

  // both zeros, sign ignored
  assign zero_o = exp_zero & man_zero;

  assign nan_o   = exp_ones & ~man_zero;
  assign infty_o = exp_ones & man_zero;

  // quiet bit is the top mantissa bit
  assign sig_nan_o = nan_o & ~operand_i.f.mantissa[`FPU_MAN_W-1];

  assign sign_o = operand_i.f.sign;

endmodule

`default_nettype wire

/* fpu_cmp_core.sv */
// combinational fp32 compare and min-max core with invalid detection
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

module fpu_cmp_core
  import fpu_cmp_pkg::*;
(
  input  fp32_u         a_i,
  input  fp32_u         b_i,
  fpu_cmp_res_if.core   res
);

  logic  a_zero;
  logic  a_nan;
  logic  a_snan;
  logic  a_sign;
  logic  b_zero;
  logic  b_nan;
  logic  b_snan;
  logic  b_sign;
  logic  mag_lt;
  logic  same_word;
  logic  eq;
  logic  lt;
  logic  le;
  logic  lt_le_inv;
  logic  eq_inv;
  fp32_u min_w;
  fp32_u max_w;
  logic  mm_inv;

  fpu_classify cls_a (
    .operand_i (a_i),
    .zero_o    (a_zero),
    .nan_o     (a_nan),
    .sig_nan_o (a_snan),
    .infty_o   (),
    .sign_o    (a_sign)
  );

  fpu_classify cls_b (
    .operand_i (b_i),
    .zero_o    (b_zero),
    .nan_o     (b_nan),
    .sig_nan_o (b_snan),
    .infty_o   (),
    .sign_o    (b_sign)
  );

  // magnitude view orders non-nan values of equal sign
  assign mag_lt    = a_i.m.mag < b_i.m.mag;
  assign same_word = a_i == b_i;

  always_comb begin
    eq        = 1'b0;
    lt        = 1'b0;
    le        = 1'b0;
    lt_le_inv = 1'b0;
    eq_inv    = 1'b0;
    if (a_nan | b_nan) begin
      // unordered, quiet nan only traps on ordered compares
      lt_le_inv = 1'b1;
      eq_inv    = a_snan | b_snan;
    end else if (a_zero & b_zero) begin
      eq = 1'b1;
      le = 1'b1;
    end else begin
      eq = same_word;
      case ({a_sign, b_sign})
        2'b00: begin
          lt = mag_lt;
          le = mag_lt | same_word;
        end
        2'b10: begin
          lt = 1'b1;
          le = 1'b1;
        end
        2'b11: begin
          // both negative so larger magnitude is smaller
          lt = ~mag_lt & ~same_word;
          le = ~mag_lt;
        end
        default: begin
          lt = 1'b0;
          le = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    mm_inv = a_snan | b_snan;
    if (a_nan & b_nan) begin
      min_w = `FPU_QNAN;
      max_w = `FPU_QNAN;
    end else if (a_nan) begin
      min_w = b_i;
      max_w = b_i;
    end else if (b_nan) begin
      min_w = a_i;
      max_w = a_i;
    end else if (a_zero & b_zero) begin
      // -0 is taken as below +0
      min_w = {a_sign | b_sign, {(`FPU_WORD_W-1){1'b0}}};
      max_w = {a_sign & b_sign, {(`FPU_WORD_W-1){1'b0}}};
    end else if (lt) begin
      min_w = a_i;
      max_w = b_i;
    end else begin
      min_w = b_i;
      max_w = a_i;
    end
  end

  assign res.eq              = eq;
  assign res.lt              = lt;
  assign res.le              = le;
  assign res.lt_le_invalid   = lt_le_inv;
  assign res.eq_invalid      = eq_inv;
  assign res.min             = min_w;
  assign res.max             = max_w;
  assign res.min_max_invalid = mm_inv;

endmodule

`default_nettype wire

/* fpu_cmp_exec.sv */
// two-stage compare pipeline with operand capture and result select by op
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

module fpu_cmp_exec
  import fpu_cmp_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   v_i,
  input  cmp_op_e                op_i,
  input  fp32_u                  a_i,
  input  fp32_u                  b_i,
  output fp32_u                  a_q_o,
  output fp32_u                  b_q_o,
  output logic                   v_o,
  output logic [`FPU_WORD_W-1:0] result_o,
  output logic                   invalid_o,
  fpu_cmp_res_if.exec            res
);

  logic                   v_q;
  cmp_op_e                op_q;
  logic [`FPU_WORD_W-1:0] sel_result;
  logic                   sel_invalid;

  // stage 1 valid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_q <= 1'b0;
    end else begin
      v_q <= v_i;
    end
  end

  // stage 1 operands and op, loaded on the strobe only
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      a_q_o <= a_i;
      b_q_o <= b_i;
      op_q  <= op_i;
    end
  end

  always_comb begin
    sel_result  = '0;
    sel_invalid = 1'b0;
    case (op_q)
      OP_EQ: begin
        sel_result[0] = res.eq;
        sel_invalid   = res.eq_invalid;
      end
      OP_LT: begin
        sel_result[0] = res.lt;
        sel_invalid   = res.lt_le_invalid;
      end
      OP_LE: begin
        sel_result[0] = res.le;
        sel_invalid   = res.lt_le_invalid;
      end
      OP_MIN: begin
        sel_result  = res.min;
        sel_invalid = res.min_max_invalid;
      end
      OP_MAX: begin
        sel_result  = res.max;
        sel_invalid = res.min_max_invalid;
      end
      // reserved codes give zero, not invalid
      default: sel_result = '0;
    endcase
  end

  // stage 2, result holds between strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_o       <= 1'b0;
      invalid_o <= 1'b0;
      result_o  <= '0;
    end else begin
      v_o       <= v_q;
      invalid_o <= v_q & sel_invalid;
      if (v_q) begin
        result_o <= sel_result;
      end
    end
  end

endmodule

`default_nettype wire

/* fpu_cmp_status.sv */
// sticky invalid flag and saturating invalid counter with clear strobe
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_status (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       v_i,
  input  logic       invalid_i,
  input  logic       clr_i,
  output logic       nv_o,
  output logic [7:0] invalid_cnt_o
);

  logic hit;
  logic cnt_full;

  // only valid results count
  assign hit      = v_i & invalid_i;
  assign cnt_full = &invalid_cnt_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      nv_o          <= 1'b0;
      invalid_cnt_o <= 8'd0;
    end else if (clr_i) begin
      // clear beats a same-cycle invalid result
      nv_o          <= 1'b0;
      invalid_cnt_o <= 8'd0;
    end else if (hit) begin
      nv_o <= 1'b1;
      if (!cnt_full) begin
        invalid_cnt_o <= invalid_cnt_o + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* fpu_cmp_top.sv */
// top level of the fp32 compare unit joining exec, core and status
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

module fpu_cmp_top
  import fpu_cmp_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   v_i,
  input  logic [2:0]             op_i,
  input  logic [`FPU_WORD_W-1:0] a_i,
  input  logic [`FPU_WORD_W-1:0] b_i,
  input  logic                   flags_clr_i,
  output logic                   v_o,
  output logic [`FPU_WORD_W-1:0] result_o,
  output logic                   invalid_o,
  output logic                   flags_nv_o,
  output logic [7:0]             invalid_cnt_o
);

  // registered operands into the core
  fp32_u a_q;
  fp32_u b_q;

  fpu_cmp_res_if res_if0 ();

  fpu_cmp_exec exec0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .v_i       (v_i),
    .op_i      (cmp_op_e'(op_i)),
    .a_i       (a_i),
    .b_i       (b_i),
    .a_q_o     (a_q),
    .b_q_o     (b_q),
    .v_o       (v_o),
    .result_o  (result_o),
    .invalid_o (invalid_o),
    .res       (res_if0.exec)
  );

  fpu_cmp_core core0 (
    .a_i (a_q),
    .b_i (b_q),
    .res (res_if0.core)
  );

  fpu_cmp_status status0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .v_i           (v_o),
    .invalid_i     (invalid_o),
    .clr_i         (flags_clr_i),
    .nv_o          (flags_nv_o),
    .invalid_cnt_o (invalid_cnt_o)
  );

endmodule

`default_nettype wire

/* fpu_cmp_properties.sv */
// concurrent assertions on the compare unit valid timing and invalid status
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_properties (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       v_i,
  input logic       flags_clr_i,
  input logic       v_o,
  input logic       invalid_o,
  input logic [7:0] invalid_cnt_o
);

  // count of failed properties
  int err_cnt = 0;

  // two stage latency, no stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i) v_o == $past(v_i, 2))
    else begin
      err_cnt++;
      $error("v_o does not follow v_i by two cycles");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) invalid_o |-> v_o)
    else begin
      err_cnt++;
      $error("invalid_o high without v_o");
    end

  // counter only drops after a clear
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (invalid_cnt_o < $past(invalid_cnt_o)) |-> $past(flags_clr_i))
    else begin
      err_cnt++;
      $error("invalid_cnt_o decreased without flags_clr_i");
    end

endmodule

bind fpu_cmp_top fpu_cmp_properties props0 (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .v_i           (v_i),
  .flags_clr_i   (flags_clr_i),
  .v_o           (v_o),
  .invalid_o     (invalid_o),
  .invalid_cnt_o (invalid_cnt_o)
);

`default_nettype wire

/* tb_fpu_cmp.sv */
// testbench for the fp32 compare unit with rule model, directed tests and output monitor
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cmp_config.svh"

module tb_fpu_cmp
  import fpu_cmp_pkg::*;
();

  localparam logic [31:0] qnan_w = `FPU_QNAN;
  localparam logic [31:0] snan_w = 32'h7fa0_0000;
  // 1.0, -2.0, -1.0, +0, -0, +inf and both nan kinds
  localparam logic [31:0] test_vals [8] = '{32'h3f80_0000, 32'hc000_0000, 32'hbf80_0000,
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, qnan_w, snan_w};

  logic        clk_i;
  logic        rst_n_i;
  logic        v_i;
  logic [2:0]  op_i;
  logic [31:0] a_i;
  logic [31:0] b_i;
  logic        flags_clr_i;
  logic        v_o;
  logic [31:0] result_o;
  logic        invalid_o;
  logic        flags_nv_o;
  logic [7:0]  invalid_cnt_o;
  logic [32:0] exp_q[$];
  logic [1:0]  sent_pipe = 2'b00;
  int          cycles = 0;

  fpu_cmp_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 2000) begin
      $display("timeout: run exceeded %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation did not finish in time");
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL t=%0t signal %s expected %h actual %h", $time, name, exp, got);
    $display("*** TEST FAILED ***");
    $fatal(1, "value mismatch on %s", name);
  endtask

  // expected {invalid, result} from the ieee compare rules
  function automatic logic [32:0] expect_op(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic        a_nan;
    logic        b_nan;
    logic        any_snan;
    logic        unordered;
    logic        zeros;
    logic        lt;
    logic        eq;
    logic [31:0] ka;
    logic [31:0] kb;
    logic [31:0] lo;
    logic [31:0] hi;
    a_nan     = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan     = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    any_snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
    unordered = a_nan || b_nan;
    zeros     = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    // order keys, every negative sorts below every positive
    ka = a[31] ? ~a : {1'b1, a[30:0]};
    kb = b[31] ? ~b : {1'b1, b[30:0]};
    eq = !unordered && (zeros || a == b);
    lt = !unordered && !zeros && (ka < kb);
    if (a_nan && b_nan) begin
      lo = qnan_w;
      hi = qnan_w;
    end else if (a_nan || b_nan) begin
      lo = a_nan ? b : a;
      hi = lo;
    end else if (zeros) begin
      lo = {a[31] | b[31], 31'd0};
      hi = {a[31] & b[31], 31'd0};
    end else begin
      lo = lt ? a : b;
      hi = lt ? b : a;
    end
    case (op)
      3'd0: return {any_snan, 31'd0, eq};
      3'd1: return {unordered, 31'd0, lt};
      3'd2: return {unordered, 31'd0, lt || eq};
      3'd3: return {any_snan, lo};
      3'd4: return {any_snan, hi};
      default: return 33'd0;
    endcase
  endfunction

  // outputs settle before the falling edge
  task automatic check_output(input logic exp_v);
    logic [32:0] exp;
    assert (v_o === exp_v) else report_mismatch("v_o", 32'(exp_v), 32'(v_o));
    if (exp_v) begin
      exp = exp_q.pop_front();
      assert (result_o === exp[31:0]) else report_mismatch("result_o", exp[31:0], result_o);
      assert (invalid_o === exp[32])
        else report_mismatch("invalid_o", 32'(exp[32]), 32'(invalid_o));
    end else begin
      assert (invalid_o === 1'b0) else report_mismatch("invalid_o", 32'd0, 32'(invalid_o));
    end
  endtask

  // each strobe is due two cycles after it is seen
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_output(sent_pipe[1]);
      sent_pipe = {sent_pipe[0], v_i};
    end
  end

  task automatic send_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
    @(posedge clk_i);
    v_i  <= 1'b1;
    op_i <= op;
    a_i  <= a;
    b_i  <= b;
    exp_q.push_back(expect_op(op, a, b));
  endtask

  task automatic drain();
    @(posedge clk_i);
    v_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic clear_flags();
    @(posedge clk_i);
    flags_clr_i <= 1'b1;
    @(posedge clk_i);
    flags_clr_i <= 1'b0;
  endtask

  task automatic check_status(input logic nv, input logic [7:0] cnt);
    @(negedge clk_i);
    assert (flags_nv_o === nv) else report_mismatch("flags_nv_o", 32'(nv), 32'(flags_nv_o));
    assert (invalid_cnt_o === cnt)
      else report_mismatch("invalid_cnt_o", 32'(cnt), 32'(invalid_cnt_o));
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    assert (v_o === 1'b0) else report_mismatch("v_o", 32'd0, 32'(v_o));
    assert (result_o === 32'd0) else report_mismatch("result_o", 32'd0, result_o);
    assert (invalid_o === 1'b0) else report_mismatch("invalid_o", 32'd0, 32'(invalid_o));
    assert (flags_nv_o === 1'b0) else report_mismatch("flags_nv_o", 32'd0, 32'(flags_nv_o));
    assert (invalid_cnt_o === 8'd0)
      else report_mismatch("invalid_cnt_o", 32'd0, 32'(invalid_cnt_o));
  endtask

  // every value pair against every op in the range
  task automatic sweep_ops(input int lo, input int hi);
    for (int op = lo; op <= hi; op++) begin
      foreach (test_vals[i]) begin
        foreach (test_vals[j]) begin
          send_op(3'(op), test_vals[i], test_vals[j]);
        end
      end
    end
    drain();
  endtask

  function automatic logic [31:0] pick_value();
    if ($urandom_range(3) == 0) begin
      return test_vals[3'($urandom_range(7))];
    end
    return $urandom();
  endfunction

  task automatic test_random();
    for (int n = 0; n < 200; n++) begin
      send_op(3'($urandom_range(7)), pick_value(), pick_value());
    end
    drain();
  endtask

  task automatic test_status();
    clear_flags();
    repeat (5) send_op(OP_LT, qnan_w, 32'h3f80_0000);
    drain();
    check_status(1'b1, 8'd5);
    clear_flags();
    check_status(1'b0, 8'd0);
    repeat (260) send_op(OP_MIN, snan_w, 32'hbf80_0000);
    drain();
    check_status(1'b1, 8'd255);
  endtask

  initial begin
    void'($urandom(715));
    rst_n_i     = 1'b0;
    v_i         = 1'b0;
    op_i        = 3'd0;
    a_i         = 32'd0;
    b_i         = 32'd0;
    flags_clr_i = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    sweep_ops(OP_EQ, OP_LE);
    sweep_ops(OP_MIN, OP_MAX);
    test_random();
    test_status();
    if (dut0.props0.err_cnt == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "bound properties reported errors");
    end
  end

endmodule

`default_nettype wire

/* fpu_cmp.f */
+incdir+.
fpu_cmp_pkg.sv
fpu_cmp_res_if.sv
fpu_classify.sv
fpu_cmp_core.sv
fpu_cmp_exec.sv
fpu_cmp_status.sv
fpu_cmp_top.sv
fpu_cmp_properties.sv
tb_fpu_cmp.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fp32 compare testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  --top-module tb_fpu_cmp -f fpu_cmp.f -o sim_fpu_cmp
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fpu_cmp > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
